/* project.f */
+incdir+.
vga_pkg.sv
timing_if.sv
wb_regs.sv
vga_timing.sv
vga_out.sv
vga_top.sv
tb_vga_top.sv

/* Makefile */
TOP  := tb_vga_top
SRCS := $(filter-out +%,$(shell cat project.f)) vga_defs.svh

obj_dir/V$(TOP): $(SRCS) project.f
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module tb_vga_top;

  import vga_pkg::*;

  localparam int FRAME_CLKS = `VGA_V_TOTAL * `VGA_H_TOTAL * 16;  // Longest frame, P = 15
  localparam int NUM_TESTS  = 6;

  logic                  clock;
  logic                  wb_rst_i;
  logic                  wbs_cyc_i;
  logic                  wbs_stb_i;
  logic                  wbs_we_i;
  logic [3:0]            wbs_sel_i;
  logic [31:0]           wbs_adr_i;
  logic [31:0]           wbs_dat_i;
  wire                   wbs_ack_o;
  wire  [31:0]           wbs_dat_o;
  wire  [`VGA_PIX_W-1:0] pixel_o;
  wire                   hsync_o;
  wire                   vsync_o;

  int          checks = 0;
  int          errors = 0;
  int          err_mark = 0;  // Error count when the current test began
  int          cyc_cnt = 0;   // Free running clock count
  int          p;             // Prescale in use
  int          lat;
  int          t0;
  int          t1;
  int          t2;
  int          n;
  int          line;
  logic [31:0] d;
  logic [31:0] rd;
  logic [31:0] s0;
  logic [31:0] adr;
  logic [3:0]  s;
  logic [7:0]  exp8;
  logic        hs_all;
  logic        vs_all;
  logic [7:0]  pix_any;
  logic [1:0]  m_ctrl;        // Model of CTRL, {bars, enable}
  logic [7:0]  m_color;
  logic [3:0]  m_presc;

  vga_top dut_i (
    .clock     (clock),
    .wb_rst_i  (wb_rst_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .pixel_o   (pixel_o),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o)
  );

  always #5 clock = ~clock;  // 10 ns period
  always @(posedge clock) cyc_cnt <= cyc_cnt + 1;

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic fail_msg(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic report_test(input string name);
    if (errors == err_mark) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Every wait ends 1 ns after a rising edge, where drive and sample happen
  task automatic step(input int cnt);
    repeat (cnt) begin
      @(posedge clock);
      #1;
    end
  endtask

  function automatic logic [31:0] reg_adr(input vga_reg_e r);
    return `VGA_WB_BASE | {26'd0, r};
  endfunction

  // One bus cycle, lat is 0 when no ack came within 4 clocks
  task automatic wb_access(input logic we, input logic [3:0] sel, input logic [31:0] a,
                           input logic [31:0] dat, output logic [31:0] rdata,
                           output int lat_o);
    lat_o = 0;
    rdata = '0;
    step(1);
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = we;
    wbs_sel_i = sel;
    wbs_adr_i = a;
    wbs_dat_i = dat;
    for (int i = 1; i <= 4; i++) begin
      step(1);
      if (wbs_ack_o) begin
        lat_o = i;
        rdata = wbs_dat_o;  // Read data valid with ack
        break;
      end
    end
    wbs_cyc_i = 1'b0;       // Master drops stb after ack
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] a, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] dummy;
    int          l;
    wb_access(1'b1, sel, a, dat, dummy, l);
    if (l == 0) fail_msg($sformatf("no ack for write to 0x%08h", a));
    else check_eq("write_ack_latency", 32'd1, l);
  endtask

  task automatic wb_read(input logic [31:0] a, output logic [31:0] dat);
    int l;
    wb_access(1'b0, 4'hF, a, 32'd0, dat, l);
    if (l == 0) fail_msg($sformatf("no ack for read from 0x%08h", a));
    else check_eq("read_ack_latency", 32'd1, l);
  endtask

  // All three writable registers against the model
  task automatic check_regs(input string tag);
    logic [31:0] v;
    wb_read(reg_adr(REG_CTRL), v);
    check_eq({tag, "_ctrl"}, {30'd0, m_ctrl}, v);
    wb_read(reg_adr(REG_COLOR), v);
    check_eq({tag, "_color"}, {24'd0, m_color}, v);
    wb_read(reg_adr(REG_PRESC), v);
    check_eq({tag, "_presc"}, {28'd0, m_presc}, v);
  endtask

  function automatic logic sync_pin(input bit vert);
    return vert ? vsync_o : hsync_o;
  endfunction

  // Wait for a fresh edge of one sync pin to lvl, t gets the clock count
  task automatic wait_edge(input bit vert, input logic lvl, output int t);
    int k;
    k = 0;
    while (sync_pin(vert) === lvl && k < 2 * FRAME_CLKS) begin
      step(1);
      k++;
    end
    while (sync_pin(vert) !== lvl && k < 2 * FRAME_CLKS) begin
      step(1);
      k++;
    end
    if (k >= 2 * FRAME_CLKS) fail_msg($sformatf("%s edge never came", vert ? "vsync" : "hsync"));
    t = cyc_cnt;
  endtask

  initial begin
    void'($urandom(33548));
    clock = 1'b0;
    wb_rst_i = 1'b0;  // Held for 3 cycles
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i = 1'b0;
    wbs_sel_i = 4'h0;
    wbs_adr_i = 32'd0;
    wbs_dat_i = 32'd0;
    m_ctrl = 2'b00;
    m_color = 8'd0;
    m_presc = 4'd0;
    repeat (3) @(posedge clock);
    #1;
    wb_rst_i = 1'b1;

    // Idle outputs after reset
    hs_all = 1'b1;
    vs_all = 1'b1;
    pix_any = 8'd0;
    repeat (200) begin
      step(1);
      hs_all = hs_all & hsync_o;
      vs_all = vs_all & vsync_o;
      pix_any = pix_any | pixel_o;
    end
    check_eq("idle_hsync", 32'd1, {31'd0, hs_all});
    check_eq("idle_vsync", 32'd1, {31'd0, vs_all});
    check_eq("idle_pixel", 32'd0, {24'd0, pix_any});
    report_test("reset_idle");

    // Random values on random byte lanes, enable kept clear
    for (int i = 0; i < 8; i++) begin
      d = $urandom & 32'hFFFF_FFFE;
      s = 4'($urandom);
      wb_write(reg_adr(REG_CTRL), d, s);
      if (s[0]) m_ctrl = d[1:0];
      d = $urandom;
      s = 4'($urandom);
      wb_write(reg_adr(REG_COLOR), d, s);
      if (s[0]) m_color = d[7:0];
      d = $urandom;
      s = 4'($urandom);
      wb_write(reg_adr(REG_PRESC), d, s);
      if (s[0]) m_presc = d[3:0];
      check_regs("roundtrip");
      adr = `VGA_WB_BASE | ((32'h10 + ($urandom % 32'hF0)) & 32'hFC);  // Hole in window
      wb_write(adr, $urandom, 4'hF);
      wb_read(adr, rd);
      check_eq("hole_read", 32'd0, rd);
    end
    check_regs("after_holes");
    report_test("register_roundtrip");

    for (int i = 0; i < 4; i++) begin
      adr = $urandom;
      if ((adr & `VGA_WB_MASK) == `VGA_WB_BASE) adr = adr ^ 32'h8000_0000;
      wb_access(1'b0, 4'hF, adr, 32'd0, rd, lat);
      check_eq("outside_read_ack", 32'd0, lat);
      wb_access(1'b1, 4'hF, adr & 32'hFFFF_FFF0, $urandom, rd, lat);  // Would hit a reg offset
      check_eq("outside_write_ack", 32'd0, lat);
    end
    check_regs("window");
    report_test("window_decode");

    p = int'($urandom % 16);
    m_presc = 4'(p);
    wb_write(reg_adr(REG_PRESC), 32'(p), 4'hF);
    m_color = 8'($urandom);
    wb_write(reg_adr(REG_COLOR), {24'd0, m_color}, 4'hF);
    m_ctrl = {1'($urandom), 1'b1};
    wb_write(reg_adr(REG_CTRL), {30'd0, m_ctrl}, 4'hF);  // Start at column 0, line 0
    for (int i = 0; i < 3; i++) begin
      wait_edge(1'b0, 1'b0, t0);
      wait_edge(1'b0, 1'b1, t1);
      wait_edge(1'b0, 1'b0, t2);
      check_eq("hsync_low", `VGA_H_SYNC * (p + 1), t1 - t0);
      check_eq("hsync_period", `VGA_H_TOTAL * (p + 1), t2 - t0);
    end
    wait_edge(1'b1, 1'b0, t0);
    wait_edge(1'b1, 1'b1, t1);
    wait_edge(1'b1, 1'b0, t2);
    check_eq("vsync_low", `VGA_V_SYNC * `VGA_H_TOTAL * (p + 1), t1 - t0);
    check_eq("vsync_period", `VGA_V_TOTAL * `VGA_H_TOTAL * (p + 1), t2 - t0);
    report_test("sync_timing");

    // One frame in solid mode, one in bars
    for (int m = 0; m < 2; m++) begin
      m_color = 8'($urandom);
      m_ctrl = {m[0], 1'b1};
      wb_write(reg_adr(REG_COLOR), {24'd0, m_color}, 4'hF);
      wb_write(reg_adr(REG_CTRL), {30'd0, m_ctrl}, 4'hF);
      wait_edge(1'b1, 1'b1, t0);  // Vsync ends at column 0 of the first back porch line
      for (int k = 0; k < `VGA_V_TOTAL; k++) begin
        line = (`VGA_V_ACTIVE + `VGA_V_FPORCH + `VGA_V_SYNC + 1 + k) % `VGA_V_TOTAL;
        wait_edge(1'b0, 1'b1, t0);
        step(`VGA_H_BPORCH * (p + 1));  // Back porch, then column 0 on the pins
        for (int col = 0; col < `VGA_H_ACTIVE; col++) begin
          step(p / 2);                  // Middle of the slot
          if (line >= `VGA_V_ACTIVE) exp8 = 8'd0;
          else if (m_ctrl[1]) exp8 = m_color + 8'(col);  // Wraps mod 256
          else exp8 = m_color;
          check_eq($sformatf("pixel line %0d col %0d", line, col), {24'd0, exp8},
                   {24'd0, pixel_o});
          step(p + 1 - p / 2);
        end
      end
    end
    report_test("pixel_contents");

    wait_edge(1'b1, 1'b0, t0);
    wb_read(reg_adr(REG_STATUS), s0);
    n = 1 + int'($urandom % 3);
    for (int i = 0; i < n; i++) begin
      wait_edge(1'b1, 1'b0, t0);  // One vsync fall per frame
    end
    wb_read(reg_adr(REG_STATUS), rd);
    check_eq("frame_count_delta", n, {16'd0, rd[15:0] - s0[15:0]});
    report_test("frame_counter");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog, four worst case frames per test plus margin
  initial begin
    #(NUM_TESTS * 4 * FRAME_CLKS * 10 + 20000);
    $display("Error: watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_top (
  input  wire                  clock,
  input  wire                  wb_rst_i,   // Active low
  input  wire                  wbs_cyc_i,
  input  wire                  wbs_stb_i,
  input  wire                  wbs_we_i,
  input  wire  [3:0]           wbs_sel_i,
  input  wire  [31:0]          wbs_adr_i,
  input  wire  [31:0]          wbs_dat_i,
  output wire                  wbs_ack_o,
  output wire  [31:0]          wbs_dat_o,
  output wire [`VGA_PIX_W-1:0] pixel_o,
  output wire                  hsync_o,    // Active low
  output wire                  vsync_o     // Active low
);

  import vga_pkg::*;

  wire vga_ctrl_t ctrl;        // Register file to both stages
  wire            frame_done;  // Timing back to frame counter

  timing_if tim_if ();

  // Wishbone slave and control registers
  wb_regs regs_i (
    .clock        (clock),
    .wb_rst_i     (wb_rst_i),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_sel_i    (wbs_sel_i),
    .wbs_adr_i    (wbs_adr_i),
    .wbs_dat_i    (wbs_dat_i),
    .frame_done_i (frame_done),
    .wbs_ack_o    (wbs_ack_o),
    .wbs_dat_o    (wbs_dat_o),
    .ctrl_o       (ctrl)
  );

  vga_timing timing_i (
    .clock        (clock),
    .wb_rst_i     (wb_rst_i),
    .ctrl_i       (ctrl),
    .tim          (tim_if.src),
    .frame_done_o (frame_done)
  );

  // Pattern and pin registers
  vga_out out_i (
    .clock    (clock),
    .wb_rst_i (wb_rst_i),
    .ctrl_i   (ctrl),
    .tim      (tim_if.dst),
    .pixel_o  (pixel_o),
    .hsync_o  (hsync_o),
    .vsync_o  (vsync_o)
  );

endmodule

`default_nettype wire

/* vga_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_out (
  input  wire                     clock,
  input  wire                     wb_rst_i,  // Active low
  input  wire vga_pkg::vga_ctrl_t ctrl_i,
  timing_if.dst                   tim,
  output logic [`VGA_PIX_W-1:0]   pixel_o,
  output logic                    hsync_o,
  output logic                    vsync_o
);

  localparam int CNT_W = `VGA_CNT_W;
  localparam int PIX_W = `VGA_PIX_W;

  logic             visible;    // Both H and V active
  logic [CNT_W-1:0] pix_sum;    // Colour plus column, top bit dropped below
  logic [PIX_W-1:0] pix_shade;
  logic [PIX_W-1:0] pixel_q;
  logic             hsync_q;
  logic             vsync_q;

  assign visible = tim.h_active && tim.v_active;
  assign pix_sum = CNT_W'(ctrl_i.color) + tim.x;

  // Shade for this slot
  always_comb begin
    if (!visible) begin
      pix_shade = '0;                      // Blank
    end else if (ctrl_i.bars) begin
      pix_shade = pix_sum[PIX_W-1:0];      // Mod 256
    end else begin
      pix_shade = ctrl_i.color;
    end
  end

  // Output registers, one clock behind the slot
  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      pixel_q <= '0;
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
    end else if (!ctrl_i.enable) begin
      pixel_q <= '0;                       // Idle: dark, syncs released
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
    end else if (tim.pix_tick) begin       // Fields only change at a tick
      pixel_q <= pix_shade;
      hsync_q <= tim.hsync_n;
      vsync_q <= tim.vsync_n;
    end
  end

  assign pixel_o = pixel_q;
  assign hsync_o = hsync_q;
  assign vsync_o = vsync_q;

  // Disabled core shows no sync on the pins, and the timing stage sits parked
  idle_sync_a: assert property (@(posedge clock) disable iff (!wb_rst_i)
    (!ctrl_i.enable && $past(!ctrl_i.enable)) |->
      (hsync_q && vsync_q && tim.hsync_n && tim.vsync_n && !tim.pix_tick));

endmodule

`default_nettype wire

/* vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module vga_timing (
  input  wire                     clock,
  input  wire                     wb_rst_i,      // Active low
  input  wire vga_pkg::vga_ctrl_t ctrl_i,
  timing_if.src                   tim,
  output logic                    frame_done_o   // Last slot of frame ends
);

  localparam int CNT_W = `VGA_CNT_W;

  // Region bounds, counter 0 is the first visible column or line
  localparam logic [CNT_W-1:0] H_ACTIVE   = CNT_W'(`VGA_H_ACTIVE);
  localparam logic [CNT_W-1:0] H_SYNC_BEG = CNT_W'(`VGA_H_ACTIVE + `VGA_H_FPORCH);
  localparam logic [CNT_W-1:0] H_SYNC_END = H_SYNC_BEG + CNT_W'(`VGA_H_SYNC);
  localparam logic [CNT_W-1:0] H_TOTAL    = CNT_W'(`VGA_H_TOTAL);
  localparam logic [CNT_W-1:0] H_LAST     = H_TOTAL - 1'b1;
  localparam logic [CNT_W-1:0] V_ACTIVE   = CNT_W'(`VGA_V_ACTIVE);
  localparam logic [CNT_W-1:0] V_SYNC_BEG = CNT_W'(`VGA_V_ACTIVE + `VGA_V_FPORCH);
  localparam logic [CNT_W-1:0] V_SYNC_END = V_SYNC_BEG + CNT_W'(`VGA_V_SYNC);
  localparam logic [CNT_W-1:0] V_LAST     = CNT_W'(`VGA_V_TOTAL - 1);

  logic [`VGA_PRESC_W-1:0] presc_cnt_q;  // Clock within current slot
  logic [CNT_W-1:0]        h_cnt_q;
  logic [CNT_W-1:0]        v_cnt_q;
  logic                    slot_end;     // Last clock of this slot
  logic                    h_last;
  logic                    v_last;

  // >= so a prescale lowered mid-slot cannot overrun
  assign slot_end = ctrl_i.enable && (presc_cnt_q >= ctrl_i.prescale);
  assign h_last   = (h_cnt_q == H_LAST);
  assign v_last   = (v_cnt_q == V_LAST);

  // Prescaler, parked at 0 while disabled
  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      presc_cnt_q <= '0;
    end else if (!ctrl_i.enable || slot_end) begin
      presc_cnt_q <= '0;
    end else begin
      presc_cnt_q <= presc_cnt_q + 1'b1;
    end
  end

  // Column and line counters
  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (!ctrl_i.enable) begin
      h_cnt_q <= '0;                 // Restart at column 0, line 0
      v_cnt_q <= '0;
    end else if (slot_end) begin
      if (h_last) begin
        h_cnt_q <= '0;
        v_cnt_q <= v_last ? '0 : v_cnt_q + 1'b1;  // Line wrap steps V
      end else begin
        h_cnt_q <= h_cnt_q + 1'b1;
      end
    end
  end

  // Slot decode, stable from one tick to the next
  assign tim.pix_tick = ctrl_i.enable && (presc_cnt_q == '0);
  assign tim.h_active = (h_cnt_q < H_ACTIVE);
  assign tim.v_active = (v_cnt_q < V_ACTIVE);
  assign tim.hsync_n  = !((h_cnt_q >= H_SYNC_BEG) && (h_cnt_q < H_SYNC_END));
  assign tim.vsync_n  = !((v_cnt_q >= V_SYNC_BEG) && (v_cnt_q < V_SYNC_END));
  assign tim.x        = h_cnt_q;

  assign frame_done_o = slot_end && h_last && v_last;

  h_range_a: assert property (@(posedge clock) disable iff (!wb_rst_i)
    h_cnt_q < H_TOTAL);

  // Frame counter in wb_regs relies on one strobe per frame
  frame_pulse_a: assert property (@(posedge clock) disable iff (!wb_rst_i)
    frame_done_o |=> !frame_done_o);

endmodule

`default_nettype wire

/* wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

module wb_regs (
  input  wire                clock,
  input  wire                wb_rst_i,      // Active low
  input  wire                wbs_cyc_i,
  input  wire                wbs_stb_i,
  input  wire                wbs_we_i,
  input  wire  [3:0]         wbs_sel_i,
  input  wire  [31:0]        wbs_adr_i,
  input  wire  [31:0]        wbs_dat_i,
  input  wire                frame_done_i,  // One strobe per finished frame
  output logic               wbs_ack_o,
  output logic [31:0]        wbs_dat_o,
  output vga_pkg::vga_ctrl_t ctrl_o
);

  import vga_pkg::*;

  logic                    sel;          // Strobe hit the window
  logic                    ack_q;
  logic                    wr_en;
  logic                    rd_en;
  logic                    off_ok;       // Offset inside the 64-byte map
  logic [5:0]              reg_off;
  logic [31:0]             rd_mux;       // Current content of addressed reg
  logic [31:0]             wr_word;      // rd_mux with written lanes replaced
  logic [31:0]             dat_q;
  logic                    clear_cnt;
  logic                    enable_q;
  logic                    bars_q;
  logic [`VGA_PIX_W-1:0]   color_q;
  logic [`VGA_PRESC_W-1:0] presc_q;
  logic [15:0]             frame_cnt_q;

  // Replace the bytes flagged in lanes
  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  lanes);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = lanes[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  assign sel     = wbs_cyc_i && wbs_stb_i &&
                   ((wbs_adr_i & `VGA_WB_MASK) == `VGA_WB_BASE);
  assign wr_en   = sel && !ack_q && wbs_we_i;   // Same edge that raises ack
  assign rd_en   = sel && !ack_q && !wbs_we_i;
  assign reg_off = wbs_adr_i[5:0];
  assign off_ok  = (wbs_adr_i[7:6] == 2'b00);   // Rest of window is unmapped
  assign wr_word = lane_merge(rd_mux, wbs_dat_i, wbs_sel_i);

  // Enable written to 0 restarts frame counting
  assign clear_cnt = wr_en && off_ok && (reg_off == REG_CTRL) && !wr_word[0];

  always_comb begin
    rd_mux = '0;
    if (off_ok) begin
      case (reg_off)
        REG_CTRL:   rd_mux = {30'd0, bars_q, enable_q};
        REG_COLOR:  rd_mux = {{(32-`VGA_PIX_W){1'b0}}, color_q};
        REG_PRESC:  rd_mux = {{(32-`VGA_PRESC_W){1'b0}}, presc_q};
        REG_STATUS: rd_mux = {16'd0, frame_cnt_q};
        default:    rd_mux = '0;  // Holes read 0
      endcase
    end
  end

  // One-cycle ack, never back to back
  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sel && !ack_q;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_en) begin
      dat_q <= rd_mux;  // Valid together with ack
    end
  end

  // Control registers, writes to holes dropped
  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      enable_q <= 1'b0;
      bars_q   <= 1'b0;
      color_q  <= '0;
      presc_q  <= '0;
    end else if (wr_en && off_ok) begin
      case (reg_off)
        REG_CTRL: begin
          enable_q <= wr_word[0];
          bars_q   <= wr_word[1];
        end
        REG_COLOR: color_q <= wr_word[`VGA_PIX_W-1:0];
        REG_PRESC: presc_q <= wr_word[`VGA_PRESC_W-1:0];
        default:   ;                   // STATUS is read only
      endcase
    end
  end

  always_ff @(posedge clock or negedge wb_rst_i) begin
    if (!wb_rst_i) begin
      frame_cnt_q <= '0;
    end else if (clear_cnt) begin
      frame_cnt_q <= '0;
    end else if (frame_done_i) begin
      frame_cnt_q <= frame_cnt_q + 16'd1;  // Wraps at 64k
    end
  end

  assign wbs_ack_o = ack_q;
  assign wbs_dat_o = dat_q;
  assign ctrl_o    = '{enable: enable_q, bars: bars_q, color: color_q, prescale: presc_q};

  // Master may hold stb through ack, still only one ack per access
  ack_single_a: assert property (@(posedge clock) disable iff (!wb_rst_i)
    ack_q |=> !ack_q);

  // No ack without a strobe into the window the clock before
  ack_cause_a: assert property (@(posedge clock) disable iff (!wb_rst_i)
    ack_q |-> $past(sel));

endmodule

`default_nettype wire

/* timing_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_defs.svh"

// One pixel slot, timing generator to output stage
interface timing_if;

  logic                  pix_tick;  // First clock of a new slot
  logic                  h_active;  // Column in visible area
  logic                  v_active;  // Line in visible area
  logic                  hsync_n;   // Active low
  logic                  vsync_n;   // Active low
  logic [`VGA_CNT_W-1:0] x;         // Column of this slot

  // Driven by vga_timing
  modport src (
    output pix_tick, h_active, v_active, hsync_n, vsync_n, x
  );

  // Read by vga_out
  modport dst (
    input pix_tick, h_active, v_active, hsync_n, vsync_n, x
  );

endinterface

`default_nettype wire

/* vga_pkg.sv */
`default_nettype none

`include "vga_defs.svh"

package vga_pkg;

  // Control word fanned out to timing and output stages
  typedef struct packed {
    logic                    enable;    // Core running
    logic                    bars;      // 1 = colour bars, 0 = solid fill
    logic [`VGA_PIX_W-1:0]   color;     // Base colour
    logic [`VGA_PRESC_W-1:0] prescale;  // Slot length is prescale+1 clocks
  } vga_ctrl_t;

  // Byte offsets inside the register window
  typedef enum logic [5:0] {
    REG_CTRL   = 6'h00,  // [0] enable, [1] bars
    REG_COLOR  = 6'h04,  // [7:0] base colour
    REG_PRESC  = 6'h08,  // [3:0] prescaler
    REG_STATUS = 6'h0C   // [15:0] frame count, read only
  } vga_reg_e;

endpackage

`default_nettype wire

/* vga_defs.svh */
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// Horizontal timing, in pixel slots
`define VGA_H_ACTIVE 16
`define VGA_H_FPORCH 2
`define VGA_H_SYNC   3
`define VGA_H_BPORCH 3
`define VGA_H_TOTAL  (`VGA_H_ACTIVE + `VGA_H_FPORCH + `VGA_H_SYNC + `VGA_H_BPORCH)

// Vertical timing, in lines
`define VGA_V_ACTIVE 8
`define VGA_V_FPORCH 1
`define VGA_V_SYNC   2
`define VGA_V_BPORCH 2
`define VGA_V_TOTAL  (`VGA_V_ACTIVE + `VGA_V_FPORCH + `VGA_V_SYNC + `VGA_V_BPORCH)

// Datapath widths
`define VGA_CNT_W   9   // H and V counters
`define VGA_PIX_W   8   // One pixel
`define VGA_PRESC_W 4   // Clocks per slot minus one

// Wishbone window, 256 bytes
`define VGA_WB_BASE 32'h3012_3400
`define VGA_WB_MASK 32'hFFFF_FF00

`endif
